//--- source/memPkg.sv
// Memory pipeline shared types
`default_nettype none

package memPkg;

    // datapath word width used by the RAM, MEM2 register and aligner
    localparam int dataWidth = 32;

    typedef enum logic [2:0] {
        loadNone  = 3'd0,
        loadByte  = 3'd1,
        loadByteU = 3'd2,
        loadHalf  = 3'd3,
        loadHalfU = 3'd4,
        loadWord  = 3'd5
    } loadType_t;

    typedef enum logic [1:0] {
        storeNone  = 2'd0,
        storeByte  = 2'd1,
        storeHalf  = 2'd2,
        storeWord  = 2'd3
    } storeType_t;

    // writeback source select
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbLink = 2'd2
    } wbSel_t;

    // MIPS ExcCode field, other codes pass through untouched
    typedef logic [4:0] excType_t;

    localparam excType_t excNone = 5'd0;
    localparam excType_t excAdEL = 5'd4;
    localparam excType_t excAdES = 5'd5;

    // one RAM read word, seen as byte lanes or half lanes
    typedef union packed {
        logic [dataWidth/8-1:0][7:0]   bytes;
        logic [dataWidth/16-1:0][15:0] halves;
    } memWord_t;

endpackage

`default_nettype wire

//--- source/memAccess.sv
// MEM stage access and alignment check
`timescale 1ns/100ps
`default_nettype none

module memAccess (
    input  logic [31:0]          memAluOut,
    input  logic [31:0]          memOutB,
    input  memPkg::loadType_t    memLoadType,
    input  memPkg::storeType_t   memStoreType,
    input  memPkg::excType_t     memExcType,
    input  logic                 memRegWr,
    input  logic                 mem2Wr,
    output memPkg::excType_t     excTypeFinal,
    output logic                 regWrFinal,
    output logic [3:0]           ramWe,
    output logic [31:0]          ramWdata
);

    logic isLoad;
    logic isHalf;
    logic isWord;
    logic misaligned;
    logic [3:0] laneMask;

    // access size from whichever kind is active
    assign isLoad = (memLoadType != memPkg::loadNone);
    assign isHalf = (memLoadType == memPkg::loadHalf) || (memLoadType == memPkg::loadHalfU)
                    || (memStoreType == memPkg::storeHalf);
    assign isWord = (memLoadType == memPkg::loadWord) || (memStoreType == memPkg::storeWord);

    assign misaligned = (isHalf && memAluOut[0]) || (isWord && (memAluOut[1:0] != 2'b00));

    // older exception wins over an alignment fault
    always_comb begin
        if (memExcType != memPkg::excNone) begin
            excTypeFinal = memExcType;
        end else if (misaligned) begin
            excTypeFinal = isLoad ? memPkg::excAdEL : memPkg::excAdES;
        end else begin
            excTypeFinal = memPkg::excNone;
        end
    end

    assign regWrFinal = memRegWr && (excTypeFinal == memPkg::excNone);

    // byte enables and replicated store data per lane
    always_comb begin
        case (memStoreType)
            memPkg::storeByte: begin
                laneMask = 4'b0001 << memAluOut[1:0];
                ramWdata = {4{memOutB[7:0]}};
            end
            memPkg::storeHalf: begin
                laneMask = memAluOut[1] ? 4'b1100 : 4'b0011;
                ramWdata = {2{memOutB[15:0]}};
            end
            memPkg::storeWord: begin
                laneMask = 4'b1111;
                ramWdata = memOutB;
            end
            default: begin
                laneMask = 4'b0000;
                ramWdata = memOutB;
            end
        endcase
    end

    // no write on a stall or for a faulting instruction
    assign ramWe = (mem2Wr && (excTypeFinal == memPkg::excNone)) ? laneMask : 4'b0000;

endmodule

`default_nettype wire

//--- source/dataRam.sv
// Byte-writable data RAM
`timescale 1ns/100ps
`default_nettype none

module dataRam #(
    parameter int ramAddrWidth = 10
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          en,
    input  logic [3:0]                    we,
    input  logic [ramAddrWidth-1:0]       addr,
    input  logic [memPkg::dataWidth-1:0]  wdata,
    output logic [memPkg::dataWidth-1:0]  rdata
);

    logic [memPkg::dataWidth-1:0] mem [2**ramAddrWidth];

    // per-byte write, only on an enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // read register holds while the pipe is stalled
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- source/mem2Reg.sv
// MEM to MEM2 pipeline register
`timescale 1ns/100ps
`default_nettype none

module mem2Reg (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          mem2Flush,
    input  logic                          mem2Wr,

    input  logic [memPkg::dataWidth-1:0]  memAluOut,
    input  logic [31:0]                   memPc,
    input  logic [31:0]                   memInstr,
    input  memPkg::wbSel_t                memWbSel,
    input  logic [4:0]                    memDst,
    input  logic [memPkg::dataWidth-1:0]  memOutB,
    // write enable after exception handling
    input  logic                          memRegWrFinal,
    input  memPkg::excType_t              memExcType,
    input  logic                          memIsBranch,
    input  logic                          memIsImmJump,
    input  logic                          memInDelaySlot,
    input  memPkg::loadType_t             memLoadType,

    output logic [memPkg::dataWidth-1:0]  mem2AluOut,
    output logic [31:0]                   mem2Pc,
    output logic [31:0]                   mem2Instr,
    output memPkg::wbSel_t                mem2WbSel,
    output logic [4:0]                    mem2Dst,
    output logic [memPkg::dataWidth-1:0]  mem2OutB,
    output logic                          mem2RegWr,
    output memPkg::excType_t              mem2ExcType,
    output logic                          mem2IsBranch,
    output logic                          mem2IsImmJump,
    output logic                          mem2InDelaySlot,
    output memPkg::loadType_t             mem2LoadType
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem2AluOut      <= '0;
            mem2Pc          <= '0;
            mem2Instr       <= '0;
            mem2WbSel       <= memPkg::wbAlu;
            mem2Dst         <= '0;
            mem2OutB        <= '0;
            mem2RegWr       <= 1'b0;
            mem2ExcType     <= memPkg::excNone;
            mem2IsBranch    <= 1'b0;
            mem2IsImmJump   <= 1'b0;
            mem2InDelaySlot <= 1'b0;
            mem2LoadType    <= memPkg::loadNone;
        end else if (mem2Flush) begin
            // flush beats write, load type included
            mem2AluOut      <= '0;
            mem2Pc          <= '0;
            mem2Instr       <= '0;
            mem2WbSel       <= memPkg::wbAlu;
            mem2Dst         <= '0;
            mem2OutB        <= '0;
            mem2RegWr       <= 1'b0;
            mem2ExcType     <= memPkg::excNone;
            mem2IsBranch    <= 1'b0;
            mem2IsImmJump   <= 1'b0;
            mem2InDelaySlot <= 1'b0;
            mem2LoadType    <= memPkg::loadNone;
        end else if (mem2Wr) begin
            mem2AluOut      <= memAluOut;
            mem2Pc          <= memPc;
            mem2Instr       <= memInstr;
            mem2WbSel       <= memWbSel;
            mem2Dst         <= memDst;
            mem2OutB        <= memOutB;
            mem2RegWr       <= memRegWrFinal;
            mem2ExcType     <= memExcType;
            mem2IsBranch    <= memIsBranch;
            mem2IsImmJump   <= memIsImmJump;
            mem2InDelaySlot <= memInDelaySlot;
            mem2LoadType    <= memLoadType;
        end
    end

endmodule

`default_nettype wire

//--- source/loadAlign.sv
// MEM2 load aligner and writeback select
`timescale 1ns/100ps
`default_nettype none

module loadAlign (
    input  logic [memPkg::dataWidth-1:0]  mem2AluOut,
    input  logic [31:0]                   mem2Pc,
    input  memPkg::wbSel_t                mem2WbSel,
    input  memPkg::loadType_t             mem2LoadType,
    input  logic                          mem2RegWr,
    input  logic [4:0]                    mem2Dst,
    input  logic [memPkg::dataWidth-1:0]  ramRdata,
    output logic                          wbRegWr,
    output logic [4:0]                    wbDst,
    output logic [memPkg::dataWidth-1:0]  wbData
);

    memPkg::memWord_t rdWord;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [memPkg::dataWidth-1:0] loadValue;

    assign rdWord = ramRdata;

    // little-endian lane pick from the low address bits
    assign byteLane = rdWord.bytes[mem2AluOut[1:0]];
    assign halfLane = rdWord.halves[mem2AluOut[1]];

    always_comb begin
        case (mem2LoadType)
            memPkg::loadByte:  loadValue = {{24{byteLane[7]}}, byteLane};
            memPkg::loadByteU: loadValue = {24'd0, byteLane};
            memPkg::loadHalf:  loadValue = {{16{halfLane[15]}}, halfLane};
            memPkg::loadHalfU: loadValue = {16'd0, halfLane};
            memPkg::loadWord:  loadValue = rdWord;
            default:           loadValue = '0;
        endcase
    end

    // link address skips the delay slot
    always_comb begin
        case (mem2WbSel)
            memPkg::wbLoad: wbData = loadValue;
            memPkg::wbLink: wbData = mem2Pc + 32'd8;
            default:        wbData = mem2AluOut;
        endcase
    end

    // write already cancelled upstream on a fault
    assign wbRegWr = mem2RegWr;
    assign wbDst   = mem2Dst;

endmodule

`default_nettype wire

//--- source/memPipe.sv
// Memory pipeline back end
`timescale 1ns/100ps
`default_nettype none

module memPipe #(
    parameter int ramAddrWidth = 10
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  mem2Wr,
    input  logic                  mem2Flush,

    input  logic [31:0]           memAluOut,
    input  logic [31:0]           memOutB,
    input  logic [31:0]           memPc,
    input  logic [31:0]           memInstr,
    input  logic [4:0]            memDst,
    input  memPkg::wbSel_t        memWbSel,
    input  logic                  memRegWr,
    input  memPkg::loadType_t     memLoadType,
    input  memPkg::storeType_t    memStoreType,
    input  memPkg::excType_t      memExcType,
    input  logic                  memIsBranch,
    input  logic                  memIsImmJump,
    input  logic                  memInDelaySlot,

    output logic                  wbRegWr,
    output logic [4:0]            wbDst,
    output logic [31:0]           wbData,
    output memPkg::excType_t      mem2ExcType,
    output logic [31:0]           mem2Pc,
    output logic                  mem2InDelaySlot,
    output logic                  mem2IsBranch,
    output logic                  mem2IsImmJump
);

    memPkg::excType_t   excTypeFinal;
    logic               regWrFinal;
    logic [3:0]         ramWe;
    logic [31:0]        ramWdata;
    logic [31:0]        ramRdata;
    logic [31:0]        mem2AluOut;
    memPkg::wbSel_t     mem2WbSel;
    memPkg::loadType_t  mem2LoadType;
    logic               mem2RegWr;
    logic [4:0]         mem2Dst;

    memAccess memAccess_inst (
        .memAluOut    (memAluOut),
        .memOutB      (memOutB),
        .memLoadType  (memLoadType),
        .memStoreType (memStoreType),
        .memExcType   (memExcType),
        .memRegWr     (memRegWr),
        .mem2Wr       (mem2Wr),
        .excTypeFinal (excTypeFinal),
        .regWrFinal   (regWrFinal),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata)
    );

    // word index of the byte address
    dataRam #(
        .ramAddrWidth (ramAddrWidth)
    ) dataRam_inst (
        .clk   (clk),
        .rstN  (rstN),
        .en    (mem2Wr),
        .we    (ramWe),
        .addr  (memAluOut[ramAddrWidth+1:2]),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    mem2Reg mem2Reg_inst (
        .clk             (clk),
        .rstN            (rstN),
        .mem2Flush       (mem2Flush),
        .mem2Wr          (mem2Wr),
        .memAluOut       (memAluOut),
        .memPc           (memPc),
        .memInstr        (memInstr),
        .memWbSel        (memWbSel),
        .memDst          (memDst),
        .memOutB         (memOutB),
        .memRegWrFinal   (regWrFinal),
        .memExcType      (excTypeFinal),
        .memIsBranch     (memIsBranch),
        .memIsImmJump    (memIsImmJump),
        .memInDelaySlot  (memInDelaySlot),
        .memLoadType     (memLoadType),
        .mem2AluOut      (mem2AluOut),
        .mem2Pc          (mem2Pc),
        .mem2Instr       (),
        .mem2WbSel       (mem2WbSel),
        .mem2Dst         (mem2Dst),
        .mem2OutB        (),
        .mem2RegWr       (mem2RegWr),
        .mem2ExcType     (mem2ExcType),
        .mem2IsBranch    (mem2IsBranch),
        .mem2IsImmJump   (mem2IsImmJump),
        .mem2InDelaySlot (mem2InDelaySlot),
        .mem2LoadType    (mem2LoadType)
    );

    loadAlign loadAlign_inst (
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2WbSel    (mem2WbSel),
        .mem2LoadType (mem2LoadType),
        .mem2RegWr    (mem2RegWr),
        .mem2Dst      (mem2Dst),
        .ramRdata     (ramRdata),
        .wbRegWr      (wbRegWr),
        .wbDst        (wbDst),
        .wbData       (wbData)
    );

endmodule

`default_nettype wire

//--- sim/memPipe_props.sv
// Memory pipeline assertions
`timescale 1ns/100ps
`default_nettype none

module memPipe_props (
    input logic             clk,
    input logic             rstN,
    input logic             mem2Wr,
    input logic             mem2Flush,
    input logic [3:0]       ramWe,
    input memPkg::excType_t excTypeFinal,
    input logic             wbRegWr,
    input logic [4:0]       wbDst,
    input logic [31:0]      wbData,
    input memPkg::excType_t mem2ExcType,
    input logic [31:0]      mem2Pc,
    input logic             mem2InDelaySlot,
    input logic             mem2IsBranch,
    input logic             mem2IsImmJump
);

    int failCount = 0;

    // no byte enable on a stall or for a faulting access
    ramWeQuiet: assert property (@(posedge clk) disable iff (!rstN)
        ((excTypeFinal != memPkg::excNone) || !mem2Wr) |-> (ramWe == 4'b0000))
        else begin
            failCount++;
            $error("RAM byte enables active during a stall or an exception");
        end

    flushClears: assert property (@(posedge clk) disable iff (!rstN)
        mem2Flush |=> !wbRegWr)
        else begin
            failCount++;
            $error("register write survived a flush");
        end

    // a stall freezes the MEM2 register and the RAM read word
    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        (!mem2Wr && !mem2Flush) |=> $stable({wbRegWr, wbDst, wbData, mem2ExcType, mem2Pc,
                                             mem2InDelaySlot, mem2IsBranch, mem2IsImmJump}))
        else begin
            failCount++;
            $error("MEM2 outputs changed while the pipeline was stalled");
        end

    noWriteOnExc: assert property (@(posedge clk) disable iff (!rstN)
        !(wbRegWr && (mem2ExcType != memPkg::excNone)))
        else begin
            failCount++;
            $error("register write together with an exception");
        end

endmodule

bind memPipe memPipe_props props_inst (.*);

`default_nettype wire

//--- sim/memPipeTb.sv
// Memory pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module memPipeTb;

    localparam int maxLines = 64;
    localparam int wordsPerLine = 8;
    localparam int resetLimit = 20;

    logic clk;
    logic rstN;
    logic mem2Wr;
    logic mem2Flush;
    logic [31:0] memAluOut;
    logic [31:0] memOutB;
    logic [31:0] memPc;
    logic [31:0] memInstr;
    logic [4:0] memDst;
    memPkg::wbSel_t memWbSel;
    logic memRegWr;
    memPkg::loadType_t memLoadType;
    memPkg::storeType_t memStoreType;
    memPkg::excType_t memExcType;
    logic memIsBranch;
    logic memIsImmJump;
    logic memInDelaySlot;

    logic wbRegWr;
    logic [4:0] wbDst;
    logic [31:0] wbData;
    memPkg::excType_t mem2ExcType;
    logic [31:0] mem2Pc;
    logic mem2InDelaySlot;
    logic mem2IsBranch;
    logic mem2IsImmJump;

    // eight words per vector as laid out in the pattern file header
    logic [31:0] patterns [maxLines*wordsPerLine];
    int numLines;
    string where;

    memPipe memPipe_inst (
        .clk             (clk),
        .rstN            (rstN),
        .mem2Wr          (mem2Wr),
        .mem2Flush       (mem2Flush),
        .memAluOut       (memAluOut),
        .memOutB         (memOutB),
        .memPc           (memPc),
        .memInstr        (memInstr),
        .memDst          (memDst),
        .memWbSel        (memWbSel),
        .memRegWr        (memRegWr),
        .memLoadType     (memLoadType),
        .memStoreType    (memStoreType),
        .memExcType      (memExcType),
        .memIsBranch     (memIsBranch),
        .memIsImmJump    (memIsImmJump),
        .memInDelaySlot  (memInDelaySlot),
        .wbRegWr         (wbRegWr),
        .wbDst           (wbDst),
        .wbData          (wbData),
        .mem2ExcType     (mem2ExcType),
        .mem2Pc          (mem2Pc),
        .mem2InDelaySlot (mem2InDelaySlot),
        .mem2IsBranch    (mem2IsBranch),
        .mem2IsImmJump   (mem2IsImmJump)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // reset held over the first five rising edges
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped during %s", where);
    endtask

    task automatic checkWord(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            stopRun($sformatf("[ERROR] %s = 0x%h, expected 0x%h (%s)", name, act, exp, where));
        end
    endtask

    task automatic checkDst(input string name, input logic [4:0] act, input logic [4:0] exp);
        if (act !== exp) begin
            stopRun($sformatf("[ERROR] %s = 0x%h, expected 0x%h (%s)", name, act, exp, where));
        end
    endtask

    task automatic checkExc(input string name, input memPkg::excType_t act,
                            input memPkg::excType_t exp);
        if (act !== exp) begin
            stopRun($sformatf("[ERROR] %s = 0x%h, expected 0x%h (%s)", name, act, exp, where));
        end
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stopRun($sformatf("[ERROR] %s = 0x%h, expected 0x%h (%s)", name, act, exp, where));
        end
    endtask

    task automatic initInputs();
        mem2Wr = 1'b0;
        mem2Flush = 1'b0;
        memAluOut = '0;
        memOutB = '0;
        memPc = '0;
        memInstr = '0;
        memDst = '0;
        memWbSel = memPkg::wbAlu;
        memRegWr = 1'b0;
        memLoadType = memPkg::loadNone;
        memStoreType = memPkg::storeNone;
        memExcType = memPkg::excNone;
        memIsBranch = 1'b0;
        memIsImmJump = 1'b0;
        memInDelaySlot = 1'b0;
    endtask

    task automatic applyLine(input int idx);
        logic [31:0] ctl;
        logic [31:0] ops;
        ctl = patterns[idx*wordsPerLine];
        ops = patterns[idx*wordsPerLine+1];
        mem2Wr = ctl[28];
        mem2Flush = ctl[24];
        memRegWr = ctl[20];
        memInDelaySlot = ctl[16];
        memIsBranch = ctl[17];
        memIsImmJump = ctl[18];
        memDst = ctl[4:0];
        memLoadType = memPkg::loadType_t'(ops[22:20]);
        memStoreType = memPkg::storeType_t'(ops[17:16]);
        memWbSel = memPkg::wbSel_t'(ops[13:12]);
        memExcType = ops[4:0];
        memAluOut = patterns[idx*wordsPerLine+2];
        memOutB = patterns[idx*wordsPerLine+3];
        memPc = patterns[idx*wordsPerLine+4];
        // instruction word is not visible at the outputs
        memInstr = 32'(idx);
    endtask

    task automatic compareLine(input int idx);
        logic [31:0] exp;
        exp = patterns[idx*wordsPerLine+5];
        where = $sformatf("vector %0d", idx);
        if (exp[28]) begin
            checkBit("wbRegWr", wbRegWr, exp[20]);
            checkBit("mem2InDelaySlot", mem2InDelaySlot, exp[16]);
            checkBit("mem2IsBranch", mem2IsBranch, exp[17]);
            checkBit("mem2IsImmJump", mem2IsImmJump, exp[18]);
            checkExc("mem2ExcType", mem2ExcType, exp[12:8]);
            checkDst("wbDst", wbDst, exp[4:0]);
            checkWord("wbData", wbData, patterns[idx*wordsPerLine+6]);
            checkWord("mem2Pc", mem2Pc, patterns[idx*wordsPerLine+7]);
        end
    endtask

    initial begin
        int resetWait;
        int cycleCount;
        initInputs();
        where = "reset";
        $readmemh("sim/memPipePatterns.txt", patterns);
        numLines = -1;
        for (int i = 0; i < maxLines; i++) begin
            if (numLines < 0 && patterns[i*wordsPerLine] === 32'hFFFF_FFFF) begin
                numLines = i;
            end
        end
        if (numLines <= 0) begin
            stopRun("pattern file holds no vectors or lacks its end marker");
        end

        // no register write and no exception while in reset
        resetWait = 0;
        while (rstN !== 1'b1) begin
            @(negedge clk);
            checkBit("wbRegWr", wbRegWr, 1'b0);
            checkExc("mem2ExcType", mem2ExcType, memPkg::excNone);
            resetWait++;
            if (resetWait > resetLimit) begin
                stopRun("timeout: reset was not released in time");
            end
        end

        // outputs of vector i-1 are checked before vector i is driven
        cycleCount = 0;
        for (int i = 0; i <= numLines; i++) begin
            @(posedge clk);
            #10;
            cycleCount++;
            if (cycleCount > numLines + 4) begin
                stopRun("timeout: the pattern loop ran past its cycle limit");
            end
            if (memPipe_inst.props_inst.failCount != 0) begin
                stopRun("a bound assertion on the pipeline failed");
            end
            if (i > 0) begin
                compareLine(i - 1);
            end
            if (i < numLines) begin
                applyLine(i);
            end else begin
                initInputs();
            end
        end

        if (memPipe_inst.props_inst.failCount == 0) begin
            $display("%0d vectors compared", numLines);
            $display("STATUS: PASS");
            $finish;
        end else begin
            stopRun($sformatf("%0d assertion failures in the bound checker",
                              memPipe_inst.props_inst.failCount));
        end
    end

endmodule

`default_nettype wire

//--- sim/memPipePatterns.txt
// ctl ops aluOut outB pc expect expData expPc, one vector per line, ctl ffffffff ends the list
// ctl: wr flush regWr {jump,branch,slot} 00 dst / ops: 00 load store wbSel 0 exc / expect: check 0 regWr flags exc dst
10000000 00030000 00000100 80f17f22 00400000 10000000 00000100 00400000 // sw
10000000 00030000 00000104 11223344 00400004 10000000 00000104 00400004
10000000 00010000 00000105 000000a5 00400008 10000000 00000105 00400008 // sb lane 1
10000000 00020000 00000106 0000c3d2 0040000c 10000000 00000106 0040000c // sh upper half
10100002 00501000 00000104 00000000 00400010 10100002 c3d2a544 00400010 // lw merged word
10100003 00101000 00000100 00000000 00400014 10100003 00000022 00400014 // lb
10100004 00101000 00000103 00000000 00400018 10100004 ffffff80 00400018
10100005 00201000 00000103 00000000 0040001c 10100005 00000080 0040001c // lbu
10100006 00201000 00000102 00000000 00400020 10100006 000000f1 00400020
10100007 00301000 00000100 00000000 00400024 10100007 00007f22 00400024 // lh
10100008 00301000 00000102 00000000 00400028 10100008 ffff80f1 00400028
10100009 00401000 00000102 00000000 0040002c 10100009 000080f1 0040002c // lhu
1010000a 00101000 00000105 00000000 00400030 1010000a ffffffa5 00400030
1010000b 00401000 00000106 00000000 00400034 1010000b 0000c3d2 00400034
10000000 00030000 00000108 5a5a0001 00400038 10000000 00000108 00400038 // sw then lw of same word
1010000c 00501000 00000108 00000000 0040003c 1010000c 5a5a0001 0040003c
1010000d 00301000 00000101 00000000 00400040 1000040d 00007f22 00400040 // misaligned lh
1010000e 00501000 00000106 00000000 00400044 1000040e c3d2a544 00400044 // misaligned lw
10000000 00020000 00000109 0000ffff 00400048 10000500 00000109 00400048 // misaligned sh
10000000 00030000 0000010a deadbeef 0040004c 10000500 0000010a 0040004c // misaligned sw
1010000f 00501000 00000108 00000000 00400050 1010000f 5a5a0001 00400050 // word unchanged
10100010 0050100c 00000101 00000000 00400054 10000c10 80f17f22 00400054 // older code kept
10000000 0003000a 00000108 12345678 00400058 10000a00 00000108 00400058
10100011 00501000 00000108 00000000 0040005c 10100011 5a5a0001 0040005c
10110012 00000000 12345678 00000000 00400060 10110012 12345678 00400060 // alu, delay slot
1014001f 00002000 00000000 00000000 00400064 1014001f 0040006c 00400064 // link
10020000 00000000 cafe0000 00000000 00400068 10020000 cafe0000 00400068 // branch
10100013 00501000 00000104 00000000 0040006c 10100013 c3d2a544 0040006c
00000000 00030000 00000104 ffffffff 00400070 10100013 c3d2a544 0040006c // stall with a store
00000000 00030000 00000104 ffffffff 00400070 10100013 c3d2a544 0040006c
10100014 00501000 00000104 00000000 00400074 10100014 c3d2a544 00400074 // store never landed
11100016 00501000 00000104 00000000 00400078 10000000 00000000 00000000 // flush beats write
10100017 00000000 00000abc 00000000 0040007c 10100017 00000abc 0040007c
01000000 00000000 00000000 00000000 00400080 10000000 00000000 00000000 // flush during stall
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 // idle, unchecked
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- files.f
source/memPkg.sv
source/memAccess.sv
source/dataRam.sv
source/mem2Reg.sv
source/loadAlign.sv
source/memPipe.sv
sim/memPipe_props.sv
sim/memPipeTb.sv

//--- Bender.yml
package:
  name: memPipe

sources:
  - source/memPkg.sv
  - source/memAccess.sv
  - source/dataRam.sv
  - source/mem2Reg.sv
  - source/loadAlign.sv
  - source/memPipe.sv
  - target: simulation
    files:
      - sim/memPipe_props.sv
      - sim/memPipeTb.sv
